// File: Makefile
# Verilator build and run of the rv_core testbench
TOP = tb_rv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rv_core.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f rv_core.f --top-module rv_core

clean:
	rm -rf obj_dir sim.log

// File: alu.sv
`timescale 1ns/100ps
// shifts use b[4:0] only
module alu (
    input  core_pkg::alu_op_t           op,
    input  logic [rv_isa_pkg::XLEN-1:0] a,
    input  logic [rv_isa_pkg::XLEN-1:0] b,
    output logic [rv_isa_pkg::XLEN-1:0] y
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = XLEN'($signed(a) < $signed(b));
            ALU_SLTU: y = XLEN'(a < b);
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $signed(a) >>> shamt;  // sign fill
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

// File: core_ifs.sv
`timescale 1ns/100ps
// plain strobes, no ready; valid is high for exactly one cycle per instruction

// decoded instruction, decode to execute
interface uop_if;
    import core_pkg::*;

    logic valid;
    uop_t uop;

    modport src (
        output valid,
        output uop
    );

    modport sink (
        input valid,
        input uop
    );
endinterface

// execute result, read by writeback and by fetch for the next PC
interface result_if;
    import rv_isa_pkg::*;

    logic                  valid;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       wb_data;
    logic [XLEN-1:0]       next_pc;

    modport src (
        output valid,
        output wb_en,
        output rd,
        output wb_data,
        output next_pc
    );

    modport sink (
        input valid,
        input wb_en,
        input rd,
        input wb_data,
        input next_pc
    );
endinterface

// File: core_pkg.sv
// internal types of the core; widths come from rv_isa_pkg
package core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N   // no operands
    } inst_fmt_t;

    typedef enum logic [1:0] {BR_NONE, BR_BRANCH, BR_JAL, BR_JALR} br_kind_t;

    typedef enum logic [1:0] {A_REG, A_PC, A_ZERO} a_sel_t;
    typedef enum logic {B_REG, B_IMM} b_sel_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::XLEN-1:0]       rs1_data;
        logic [rv_isa_pkg::XLEN-1:0]       rs2_data;
        logic [rv_isa_pkg::XLEN-1:0]       imm;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] rd;
        inst_fmt_t                         fmt;
        alu_op_t                           alu_op;
        br_kind_t                          br_kind;
        logic [2:0]                        funct3;
        a_sel_t                            a_sel;
        b_sel_t                            b_sel;
        logic                              we;   // writes rd, before the x0 test
    } uop_t;

endpackage

// File: decode_unit.sv
`timescale 1ns/100ps
// loads, stores and SYSTEM decode to no-ops that fall through to PC+4
module decode_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              inst_valid,
    input  logic [rv_isa_pkg::XLEN-1:0]       inst,
    input  logic [rv_isa_pkg::XLEN-1:0]       pc,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_isa_pkg::XLEN-1:0]       rs2_data,
    uop_if.src                                uop
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    inst_fmt_t       fmt;
    logic [XLEN-1:0] imm;
    alu_op_t         alu_op;
    uop_t            dec;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    always_comb begin
        case (opcode)
            OPC_OP:                                      fmt = FMT_R;
            OPC_OP_IMM, OPC_JALR, OPC_LOAD, OPC_SYSTEM: fmt = FMT_I;
            OPC_STORE:                                   fmt = FMT_S;
            OPC_BRANCH:                                  fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:                          fmt = FMT_U;
            OPC_JAL:                                     fmt = FMT_J;
            default:                                     fmt = FMT_N;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (fmt)
            FMT_I:   imm = {{20{inst[31]}}, inst[31:20]};
            FMT_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            FMT_U:   imm = {inst[31:12], 12'b0};
            FMT_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // address and target sums
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADD:  alu_op = (fmt == FMT_R && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;  // imm[11:5] for SRAI
                F3_OR:   alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        dec          = '0;
        dec.pc       = pc;
        dec.rs1_data = rs1_data;
        dec.rs2_data = rs2_data;
        dec.imm      = imm;
        dec.rd       = inst[11:7];
        dec.fmt      = fmt;
        dec.alu_op   = alu_op;
        dec.funct3   = funct3;
        dec.a_sel    = A_REG;
        dec.b_sel    = B_IMM;
        dec.br_kind  = BR_NONE;
        dec.we       = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.b_sel = B_REG;
                dec.we    = 1'b1;
            end
            OPC_OP_IMM: dec.we = 1'b1;
            OPC_LUI: begin
                dec.a_sel = A_ZERO;
                dec.we    = 1'b1;
            end
            OPC_AUIPC: begin
                dec.a_sel = A_PC;
                dec.we    = 1'b1;
            end
            OPC_JAL: begin
                dec.a_sel   = A_PC;
                dec.br_kind = BR_JAL;
                dec.we      = 1'b1;
            end
            OPC_JALR: begin
                dec.br_kind = BR_JALR;
                dec.we      = 1'b1;
            end
            OPC_BRANCH: begin
                dec.a_sel   = A_PC;
                dec.br_kind = BR_BRANCH;
            end
            default: ;  // unsupported, no write
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            uop.valid <= 1'b0;
        else
            uop.valid <= inst_valid;
    end

    always_ff @(posedge clk) begin
        if (inst_valid)
            uop.uop <= dec;
    end

endmodule

// File: execute_unit.sv
`timescale 1ns/100ps
// combinational; result is valid in the same cycle as the micro-op
module execute_unit (
    uop_if.sink   uop,
    result_if.src res
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    uop_t            u;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] seq_pc;  // PC+4, also the link value
    logic            taken;

    assign u      = uop.uop;
    assign seq_pc = u.pc + XLEN'(INST_BYTES);

    always_comb begin
        case (u.a_sel)
            A_PC:    a = u.pc;
            A_ZERO:  a = '0;   // LUI
            default: a = u.rs1_data;
        endcase
        b = (u.b_sel == B_REG) ? u.rs2_data : u.imm;
    end

    alu u_alu (
        .op (u.alu_op),
        .a  (a),
        .b  (b),
        .y  (alu_y)
    );

    always_comb begin
        case (u.funct3)
            F3_BEQ:  taken = (u.rs1_data == u.rs2_data);
            F3_BNE:  taken = (u.rs1_data != u.rs2_data);
            F3_BLT:  taken = ($signed(u.rs1_data) < $signed(u.rs2_data));
            F3_BGE:  taken = ($signed(u.rs1_data) >= $signed(u.rs2_data));
            F3_BLTU: taken = (u.rs1_data < u.rs2_data);
            F3_BGEU: taken = (u.rs1_data >= u.rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (u.br_kind)
            BR_JAL:    res.next_pc = alu_y;
            BR_JALR:   res.next_pc = {alu_y[XLEN-1:1], 1'b0};
            BR_BRANCH: res.next_pc = taken ? alu_y : seq_pc;
            default:   res.next_pc = seq_pc;
        endcase
    end

    assign res.valid   = uop.valid;
    assign res.wb_en   = u.we;
    assign res.rd      = u.rd;
    assign res.wb_data = (u.br_kind == BR_JAL || u.br_kind == BR_JALR) ? seq_pc : alu_y;

endmodule

// File: fetch_unit.sv
`timescale 1ns/100ps
// one fetch outstanding; inst_valid may arrive in the request cycle or any cycle after it
module fetch_unit (
    input  logic                        clk,
    input  logic                        reset,
    result_if.sink                      res,
    input  logic                        inst_valid,
    output logic                        fetch_req,
    output logic [rv_isa_pkg::XLEN-1:0] pc
);
    import rv_isa_pkg::*;

    logic started;  // first request already issued
    logic req_q;
    logic pending;  // request out, instruction not yet seen

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_PC;
            started <= 1'b0;
            req_q   <= 1'b0;
            pending <= 1'b0;
        end else begin
            started <= 1'b1;
            req_q   <= !started || res.valid;  // boot request, then one per retire
            if (res.valid)
                pc <= res.next_pc;
            if (inst_valid)
                pending <= 1'b0;
            else if (req_q)
                pending <= 1'b1;
        end
    end

    assign fetch_req = req_q;

    // the environment answers only a request it has seen
    a_inst_after_req: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> (fetch_req || pending))
        else $error("inst_valid without an outstanding fetch_req");

endmodule

// File: gpr_file.sv
`timescale 1ns/100ps
// no write-to-read bypass; a single instruction in flight never needs one
module gpr_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_isa_pkg::XLEN-1:0]       rs2_data,
    input  logic                              we,
    input  logic [rv_isa_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rv_isa_pkg::XLEN-1:0]       wdata
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // writeback filters rd == 0 before it gets here
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        we |-> (waddr != '0))
        else $error("register file write to x0");

endmodule

// File: result_unit.sv
`timescale 1ns/100ps
// writes the register file at the edge after execute; retire report lags by that edge
module result_unit (
    input  logic                              clk,
    input  logic                              reset,
    result_if.sink                            res,
    output logic                              gpr_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] gpr_waddr,
    output logic [rv_isa_pkg::XLEN-1:0]       gpr_wdata,
    output logic                              retire_valid,
    output logic                              retire_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_isa_pkg::XLEN-1:0]       retire_data
);

    // x0 is never written
    assign gpr_we    = res.valid && res.wb_en && (res.rd != '0);
    assign gpr_waddr = res.rd;
    assign gpr_wdata = res.wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= res.valid;
            retire_we    <= gpr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (res.valid) begin
            retire_rd   <= res.rd;
            retire_data <= res.wb_data;
        end
    end

    // one instruction in flight, so a result never lasts two cycles
    a_valid_one_cycle: assert property (@(posedge clk) disable iff (reset)
        res.valid |=> !res.valid)
        else $error("result valid for two cycles in a row");

endmodule

// File: rv_core.f
rv_isa_pkg.sv
core_pkg.sv
core_ifs.sv
alu.sv
gpr_file.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
result_unit.sv
rv_core.sv
tb_rv_core.sv

// File: rv_core.sv
`timescale 1ns/100ps
// RV32I integer subset, one instruction in flight; loads, stores and SYSTEM retire as no-ops
module rv_core (
    input  logic                              clk,
    input  logic                              reset,
    output logic                              fetch_req,
    output logic [rv_isa_pkg::XLEN-1:0]       fetch_pc,
    input  logic                              inst_valid,
    input  logic [rv_isa_pkg::XLEN-1:0]       inst,
    output logic                              retire_valid,
    output logic                              retire_we,
    output logic [rv_isa_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_isa_pkg::XLEN-1:0]       retire_data
);
    import rv_isa_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  gpr_we;
    logic [REG_ADDR_W-1:0] gpr_waddr;
    logic [XLEN-1:0]       gpr_wdata;

    uop_if    uop_bus ();
    result_if res_bus ();

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .res        (res_bus.sink),
        .inst_valid (inst_valid),
        .fetch_req  (fetch_req),
        .pc         (fetch_pc)
    );

    decode_unit u_decode (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (fetch_pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .uop        (uop_bus.src)
    );

    gpr_file u_gpr (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (gpr_we),
        .waddr    (gpr_waddr),
        .wdata    (gpr_wdata)
    );

    execute_unit u_execute (
        .uop (uop_bus.sink),
        .res (res_bus.src)
    );

    result_unit u_result (
        .clk          (clk),
        .reset        (reset),
        .res          (res_bus.sink),
        .gpr_we       (gpr_we),
        .gpr_waddr    (gpr_waddr),
        .gpr_wdata    (gpr_wdata),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

// File: rv_isa_pkg.sv
// RV32I base encodings only; compressed, CSR and privileged fields are not described
package rv_isa_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;
    localparam int INST_BYTES = 4;

    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // recognized for format only, executed as no-ops
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // integer op funct3, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

endpackage

// File: tb_rv_core.sv
`timescale 1ns/100ps
// directed tests against a behavioral RV32I model; memory answers each fetch after 0 to 3 cycles
module tb_rv_core;
    import rv_isa_pkg::*;

    localparam int NUM_INSTS   = 48;               // instructions issued over all tests
    localparam int CYCLE_LIMIT = 40 * NUM_INSTS;
    localparam logic [31:0] RAND_SEED = 32'h7f722982;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  fetch_req;
    logic [XLEN-1:0]       fetch_pc;
    logic                  inst_valid;
    logic [XLEN-1:0]       inst;
    logic                  retire_valid;
    logic                  retire_we;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_data;

    logic [31:0] prog [logic [31:0]];  // program, by fetch address
    logic [31:0] mregs [32];           // model register file
    logic [31:0] mpc;                  // model PC
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    rv_core dut0 (
        .clk          (clk),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_pc     (fetch_pc),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .retire_valid (retire_valid),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: %s expected %h, actual %h", test, what, exp, act);
        end
    endtask

    // instruction encoders
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], f3, off[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input int rs1,
                                           input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] j_type(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
    endfunction

    // integer result as the ISA defines it
    function automatic logic [31:0] int_op(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] x, input logic [31:0] y);
        case (f3)
            F3_ADD:  return alt ? x - y : x + y;
            F3_SLL:  return x << y[4:0];
            F3_SLT:  return {31'b0, ($signed(x) < $signed(y))};
            F3_SLTU: return {31'b0, (x < y)};
            F3_XOR:  return x ^ y;
            F3_SR:   return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            F3_OR:   return x | y;
            default: return x & y;
        endcase
    endfunction

    // applies one instruction to the model, returns the expected retire
    task automatic model_exec(input logic [31:0] ins, output logic exp_we,
                              output logic [4:0] exp_rd, output logic [31:0] exp_data);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        logic [31:0] npc;
        logic        writes;
        logic        taken;
        opc    = ins[6:0];
        f3     = ins[14:12];
        a      = mregs[ins[19:15]];
        b      = mregs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u  = {ins[31:12], 12'b0};
        imm_j  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        npc    = mpc + 32'd4;
        writes = 1'b1;
        exp_data = '0;
        case (opc)
            OPC_OP:     exp_data = int_op(f3, ins[31:25] == F7_ALT, a, b);
            OPC_OP_IMM: exp_data = int_op(f3, f3 == F3_SR && ins[31:25] == F7_ALT, a, imm_i);
            OPC_LUI:    exp_data = imm_u;
            OPC_AUIPC:  exp_data = mpc + imm_u;
            OPC_JAL: begin
                exp_data = mpc + 32'd4;
                npc      = mpc + imm_j;
            end
            OPC_JALR: begin
                exp_data = mpc + 32'd4;
                npc      = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                writes = 1'b0;
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    npc = mpc + imm_b;
            end
            default: writes = 1'b0;  // loads, stores, SYSTEM
        endcase
        exp_rd = ins[11:7];
        exp_we = writes && (exp_rd != 5'd0);
        if (exp_we)
            mregs[exp_rd] = exp_data;
        mpc = npc;
    endtask

    task automatic wait_fetch();
        while (fetch_req !== 1'b1)
            @(negedge clk);
    endtask

    // memory side: answer the pending fetch after a random delay
    task automatic serve_fetch();
        int unsigned delay;
        delay = $urandom % 4;
        repeat (delay) @(negedge clk);
        if (!prog.exists(fetch_pc)) begin
            errors++;
            $display("fetch from address %h where no instruction was loaded", fetch_pc);
            inst = 32'h0000_0013;
        end else begin
            inst = prog[fetch_pc];
        end
        inst_valid = 1'b1;
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic run_one(input string test, input logic [31:0] ins);
        int          lat;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_data;
        prog[mpc] = ins;
        wait_fetch();
        check_value(test, "fetch_pc", mpc, fetch_pc);
        serve_fetch();
        lat = 1;
        while (retire_valid !== 1'b1) begin
            @(negedge clk);
            lat++;
        end
        check_value(test, "retire latency", 32'd2, 32'(lat));
        check_value(test, "fetch_req at retire", 32'd1, 32'(fetch_req));
        model_exec(ins, exp_we, exp_rd, exp_data);
        check_value(test, "retire_we", 32'(exp_we), 32'(retire_we));
        if (exp_we) begin
            check_value(test, "retire_rd", 32'(exp_rd), 32'(retire_rd));
            check_value(test, "retire_data", exp_data, retire_data);
        end
    endtask

    task automatic test_reset();
        foreach (mregs[i])
            mregs[i] = '0;
        mpc   = RESET_PC;
        reset = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_value("reset", "retire_valid", 32'd0, 32'(retire_valid));
        end
        reset = 1'b0;
        while (fetch_req !== 1'b1) begin
            @(negedge clk);
            check_value("reset", "retire_valid", 32'd0, 32'(retire_valid));
        end
        check_value("reset", "first fetch_pc", RESET_PC, fetch_pc);
    endtask

    task automatic test_alu();
        run_one("alu", i_type(OPC_OP_IMM, F3_ADD, 1, 0, 100));
        run_one("alu", i_type(OPC_OP_IMM, F3_ADD, 2, 0, -7));   // negative immediate
        run_one("alu", r_type(7'b0, F3_ADD, 3, 1, 2));
        run_one("alu", r_type(F7_ALT, F3_ADD, 4, 2, 1));        // sub
        run_one("alu", r_type(7'b0, F3_SLL, 5, 1, 2));          // shift by 25
        run_one("alu", r_type(7'b0, F3_SLT, 6, 2, 1));
        run_one("alu", r_type(7'b0, F3_SLTU, 7, 2, 1));
        run_one("alu", r_type(7'b0, F3_XOR, 8, 1, 2));
        run_one("alu", r_type(7'b0, F3_SR, 9, 2, 1));
        run_one("alu", r_type(F7_ALT, F3_SR, 10, 2, 1));        // sra
        run_one("alu", r_type(7'b0, F3_OR, 11, 1, 2));
        run_one("alu", r_type(7'b0, F3_AND, 12, 1, 2));
        run_one("alu", i_type(OPC_OP_IMM, F3_SLL, 13, 2, 31));
        run_one("alu", i_type(OPC_OP_IMM, F3_SLT, 14, 1, -1));
        run_one("alu", i_type(OPC_OP_IMM, F3_SLTU, 15, 1, -1));
        run_one("alu", i_type(OPC_OP_IMM, F3_XOR, 16, 2, -1));
        run_one("alu", i_type(OPC_OP_IMM, F3_SR, 17, 2, 3));
        run_one("alu", i_type(OPC_OP_IMM, F3_SR, 18, 2, 'h403)); // srai
        run_one("alu", i_type(OPC_OP_IMM, F3_OR, 19, 1, -2048));
        run_one("alu", i_type(OPC_OP_IMM, F3_AND, 20, 2, 'h7f0));
        run_one("alu", r_type(7'b0, F3_ADD, 0, 1, 2));          // rd x0, no write
        run_one("alu", i_type(OPC_OP_IMM, F3_ADD, 21, 0, 5));
        run_one("alu", r_type(7'b0, F3_ADD, 22, 0, 0));
    endtask

    task automatic test_upper();
        run_one("upper", u_type(OPC_LUI, 1, 'habcde));
        run_one("upper", u_type(OPC_AUIPC, 2, 'h12345));
        run_one("upper", u_type(OPC_AUIPC, 3, 'hfffff));
    endtask

    task automatic test_branch();
        run_one("branch", i_type(OPC_OP_IMM, F3_ADD, 1, 0, -5));
        run_one("branch", i_type(OPC_OP_IMM, F3_ADD, 2, 0, 7));
        run_one("branch", b_type(F3_BEQ, 1, 1, 16));    // taken
        run_one("branch", b_type(F3_BEQ, 1, 2, 16));
        run_one("branch", b_type(F3_BNE, 1, 2, -12));   // taken, backward
        run_one("branch", b_type(F3_BNE, 1, 1, -12));
        run_one("branch", b_type(F3_BLT, 1, 2, 20));    // taken
        run_one("branch", b_type(F3_BLT, 2, 1, 20));
        run_one("branch", b_type(F3_BGE, 2, 1, -8));    // taken
        run_one("branch", b_type(F3_BGE, 1, 2, -8));
        run_one("branch", b_type(F3_BLTU, 2, 1, 12));   // taken
        run_one("branch", b_type(F3_BLTU, 1, 2, 12));
        run_one("branch", b_type(F3_BGEU, 1, 2, -16));  // taken
        run_one("branch", b_type(F3_BGEU, 2, 1, -16));
    endtask

    task automatic test_jump();
        run_one("jump", j_type(1, 24));
        run_one("jump", j_type(0, -8));
        run_one("jump", i_type(OPC_JALR, 3'b000, 7, 1, 9));    // odd sum, bit 0 cleared
        run_one("jump", i_type(OPC_JALR, 3'b000, 0, 7, -3));
    endtask

    task automatic test_unsupported();
        run_one("unsupported", i_type(OPC_LOAD, 3'b010, 5, 1, 0));
        run_one("unsupported", s_type(3'b010, 1, 2, 4));
        run_one("unsupported", 32'h0000_0073);                   // ecall
        run_one("unsupported", r_type(7'b0, F3_ADD, 23, 5, 0));  // x5 kept its value
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        test_reset();
        test_alu();
        test_upper();
        test_branch();
        test_jump();
        test_unsupported();
        wait_fetch();
        check_value("end", "fetch_pc", mpc, fetch_pc);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
